//--- design/byte_bus_engine.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module byte_bus_engine (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start_i,
  input  mem_pkg::mem_req_t         cmd_i,
  output logic                      busy_o,
  output logic                      done_o,
  output mem_pkg::word_t            rdata_o,
  output logic [`MEM_ADDR_BITS-1:0] ram_addr_o,
  output logic                      ram_we_o,
  output logic [7:0]                ram_dout_o,
  input  logic [7:0]                ram_din_i
);

  import mem_pkg::*;

  // control
  logic       busy_q;
  logic       done_q;
  logic       wr_q;
  size_e      es_q;
  logic [1:0] cu_q;
  logic       issue_q;
  logic       rd_vld_q;
  logic       ram_we_q;

  // payload
  logic [1:0]                rd_off_q;
  word_t                     wdata_q;
  word_t                     asm_q;
  logic [`MEM_ADDR_BITS-1:0] ram_addr_q;
  logic [7:0]                ram_dout_q;

  logic       accept;
  logic       advance;
  logic [1:0] cu_next;

  assign accept  = start_i && !busy_q;
  assign cu_next = cu_q + 2'd1;

  // move to the next byte until the last offset is on the bus
  assign advance = busy_q && (cu_q != es_q) && (wr_q || issue_q);

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign rdata_o    = asm_q;
  assign ram_addr_o = ram_addr_q;
  assign ram_we_o   = ram_we_q;
  assign ram_dout_o = ram_dout_q;

  // --------------------------------------------------
  // sequencing
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      wr_q     <= 1'b0;
      es_q     <= SZ_BYTE;
      cu_q     <= 2'd0;
      issue_q  <= 1'b0;
      rd_vld_q <= 1'b0;
      ram_we_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q   <= 1'b1;
        wr_q     <= cmd_i.write;
        es_q     <= cmd_i.size;
        cu_q     <= 2'd0;
        issue_q  <= !cmd_i.write;
        rd_vld_q <= 1'b0;
        ram_we_q <= cmd_i.write;
      end else if (busy_q && wr_q) begin
        // write: last byte goes out this cycle, finish at the edge
        if (cu_q == es_q) begin
          ram_we_q <= 1'b0;
          busy_q   <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          cu_q <= cu_next;
        end
      end else if (busy_q) begin
        // read: the byte for the address shown now arrives next cycle
        rd_vld_q <= issue_q;
        if (advance) begin
          cu_q <= cu_next;
        end else if (issue_q) begin
          issue_q <= 1'b0;
        end
        if (rd_vld_q && (rd_off_q == es_q)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // address, write byte and read assembly
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      ram_addr_q <= cmd_i.addr[`MEM_ADDR_BITS-1:0];
      ram_dout_q <= cmd_i.wdata[7:0];
      wdata_q    <= cmd_i.wdata;
      // unread upper bytes stay zero
      asm_q      <= '0;
    end else if (busy_q) begin
      if (advance) begin
        ram_addr_q <= ram_addr_q + 1'b1;
        ram_dout_q <= wdata_q[{cu_next, 3'b000} +: 8];
      end
      rd_off_q <= cu_q;
      if (rd_vld_q) begin
        asm_q[{rd_off_q, 3'b000} +: 8] <= ram_din_i;
      end
    end
  end

endmodule

//--- design/icache.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module icache (
  input  logic           clk,
  input  logic           rst,
  input  mem_pkg::addr_t lookup_addr_i,
  output logic           hit_o,
  output mem_pkg::word_t hit_data_o,
  input  logic           fill_i,
  input  mem_pkg::addr_t fill_addr_i,
  input  mem_pkg::word_t fill_data_i,
  input  logic           inval_i,
  input  mem_pkg::addr_t inval_addr_i
);

  import mem_pkg::*;

  localparam int IDX_LO = 2;
  localparam int IDX_HI = `ICACHE_IDX_BITS + 1;
  localparam int TAG_LO = `ICACHE_IDX_BITS + 2;
  localparam int TAG_HI = `MEM_ADDR_BITS - 1;

  icache_entry_t entries [`ICACHE_ENTRIES];

  logic [`ICACHE_IDX_BITS-1:0] look_idx;
  logic [`ICACHE_IDX_BITS-1:0] fill_idx;
  logic [`ICACHE_IDX_BITS-1:0] inval_idx;
  tag_t                        look_tag;
  tag_t                        fill_tag;
  tag_t                        inval_tag;
  icache_entry_t               look_entry;
  logic                        inval_match;

  assign look_idx  = lookup_addr_i[IDX_HI:IDX_LO];
  assign look_tag  = lookup_addr_i[TAG_HI:TAG_LO];
  assign fill_idx  = fill_addr_i[IDX_HI:IDX_LO];
  assign fill_tag  = fill_addr_i[TAG_HI:TAG_LO];
  assign inval_idx = inval_addr_i[IDX_HI:IDX_LO];
  assign inval_tag = inval_addr_i[TAG_HI:TAG_LO];

  // --------------------------------------------------
  // lookup, purely combinational
  // --------------------------------------------------
  assign look_entry = entries[look_idx];
  assign hit_o      = look_entry.valid && (look_entry.tag == look_tag);
  assign hit_data_o = look_entry.data;

  // a fill landing in the same slot this cycle is what the write would hit
  always_comb begin
    if (fill_i && (fill_idx == inval_idx)) begin
      inval_match = (fill_tag == inval_tag);
    end else begin
      inval_match = (entries[inval_idx].tag == inval_tag);
    end
  end

  // --------------------------------------------------
  // fill and invalidate
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ICACHE_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      if (fill_i) begin
        entries[fill_idx] <= '{valid: 1'b1, tag: fill_tag, data: fill_data_i};
      end
      // applied after the fill so a write always kills the stale word
      if (inval_i && inval_match) begin
        entries[inval_idx].valid <= 1'b0;
      end
    end
  end

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_req_i,
  input  mem_pkg::mem_req_t data_cmd_i,
  input  logic              fetch_req_i,
  input  mem_pkg::addr_t    fetch_addr_i,
  input  logic              fetch_hit_i,
  output logic              bus_start_o,
  output mem_pkg::mem_req_t bus_cmd_o,
  input  logic              bus_busy_i,
  input  logic              bus_done_i,
  input  mem_pkg::word_t    bus_rdata_i,
  output logic              data_done_o,
  output mem_pkg::word_t    data_rdata_o,
  output logic              fetch_miss_done_o,
  output logic              fill_o,
  output logic              inval_o,
  output mem_pkg::addr_t    inval_addr_o
);

  import mem_pkg::*;

  grant_e   grant_q;
  logic     fetch_seen_q;
  logic     data_ign;
  logic     fetch_ign;
  logic     data_pend;
  logic     fetch_pend;
  mem_req_t fetch_cmd;

  // completions go to whoever holds the bus
  assign data_done_o       = bus_done_i && (grant_q == GNT_DATA);
  assign fetch_miss_done_o = bus_done_i && (grant_q == GNT_FETCH);
  assign data_rdata_o      = bus_rdata_i;

  // requester still shows the finished payload during its done cycle
  assign data_ign  = data_done_o;
  assign fetch_ign = fetch_miss_done_o;

  assign data_pend  = data_req_i && !data_ign;
  assign fetch_pend = fetch_seen_q && fetch_req_i && !fetch_hit_i && !fetch_ign;

  // misses always read a whole aligned word
  assign fetch_cmd = '{addr: {fetch_addr_i[31:2], 2'b00}, wdata: '0, write: 1'b0, size: SZ_WORD};

  // data wins whenever both are waiting
  assign bus_start_o = !bus_busy_i && (data_pend || fetch_pend);
  assign bus_cmd_o   = data_pend ? data_cmd_i : fetch_cmd;

  assign fill_o       = fetch_miss_done_o;
  assign inval_o      = bus_start_o && data_pend && data_cmd_i.write;
  assign inval_addr_o = data_cmd_i.addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q      <= GNT_NONE;
      fetch_seen_q <= 1'b0;
    end else begin
      // a miss is qualified one cycle before it may take the bus
      fetch_seen_q <= fetch_req_i && !fetch_hit_i && !fetch_ign;
      if (bus_start_o) begin
        grant_q <= data_pend ? GNT_DATA : GNT_FETCH;
      end else if (bus_done_i) begin
        grant_q <= GNT_NONE;
      end
    end
  end

endmodule

//--- design/mem_ctrl.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      data_req_i,
  input  mem_pkg::mem_req_t         data_cmd_i,
  output logic                      data_done_o,
  output mem_pkg::word_t            data_rdata_o,
  input  logic                      fetch_req_i,
  input  mem_pkg::addr_t            fetch_addr_i,
  output logic                      fetch_done_o,
  output mem_pkg::word_t            fetch_data_o,
  output logic [`MEM_ADDR_BITS-1:0] ram_addr_o,
  output logic                      ram_we_o,
  output logic [7:0]                ram_dout_o,
  input  logic [7:0]                ram_din_i
);

  import mem_pkg::*;

  logic     fetch_hit;
  word_t    fetch_hit_data;
  logic     hit_done_q;
  word_t    hit_word_q;
  logic     miss_done;
  logic     fill;
  logic     inval;
  addr_t    inval_addr;
  logic     bus_start;
  mem_req_t bus_cmd;
  logic     bus_busy;
  logic     bus_done;
  word_t    bus_rdata;

  icache u_icache (
    .clk          (clk),
    .rst          (rst),
    .lookup_addr_i(fetch_addr_i),
    .hit_o        (fetch_hit),
    .hit_data_o   (fetch_hit_data),
    .fill_i       (fill),
    .fill_addr_i  (fetch_addr_i),
    .fill_data_i  (bus_rdata),
    .inval_i      (inval),
    .inval_addr_i (inval_addr)
  );

  mem_arbiter u_arbiter (
    .clk              (clk),
    .rst              (rst),
    .data_req_i       (data_req_i),
    .data_cmd_i       (data_cmd_i),
    .fetch_req_i      (fetch_req_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_hit_i      (fetch_hit),
    .bus_start_o      (bus_start),
    .bus_cmd_o        (bus_cmd),
    .bus_busy_i       (bus_busy),
    .bus_done_i       (bus_done),
    .bus_rdata_i      (bus_rdata),
    .data_done_o      (data_done_o),
    .data_rdata_o     (data_rdata_o),
    .fetch_miss_done_o(miss_done),
    .fill_o           (fill),
    .inval_o          (inval),
    .inval_addr_o     (inval_addr)
  );

  byte_bus_engine u_engine (
    .clk       (clk),
    .rst       (rst),
    .start_i   (bus_start),
    .cmd_i     (bus_cmd),
    .busy_o    (bus_busy),
    .done_o    (bus_done),
    .rdata_o   (bus_rdata),
    .ram_addr_o(ram_addr_o),
    .ram_we_o  (ram_we_o),
    .ram_dout_o(ram_dout_o),
    .ram_din_i (ram_din_i)
  );

  // hits finish one edge after the lookup, off the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_done_q <= 1'b0;
    end else begin
      hit_done_q <= fetch_req_i && fetch_hit && !fetch_done_o;
    end
  end

  always_ff @(posedge clk) begin
    hit_word_q <= fetch_hit_data;
  end

  assign fetch_done_o = hit_done_q || miss_done;
  assign fetch_data_o = hit_done_q ? hit_word_q : bus_rdata;

endmodule

//--- design/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [`WORD_BITS-1:0] word_t;
  typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

  // value is the offset of the last byte of the access
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd3
  } size_e;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
    size_e size;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
  } icache_entry_t;

  // current owner of the byte bus
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_DATA,
    GNT_FETCH
  } grant_e;

endpackage

//--- include/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address bits decoded by the ram (128 KiB)
`define MEM_ADDR_BITS 17

// instruction cache geometry, one word per entry
`define ICACHE_IDX_BITS 6
`define ICACHE_ENTRIES (1 << `ICACHE_IDX_BITS)

// tag sits above the index and the byte offset
`define ICACHE_TAG_BITS (`MEM_ADDR_BITS - `ICACHE_IDX_BITS - 2)

// data path width
`define WORD_BITS 32

`endif

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_mem_ctrl -o tb_mem_ctrl \
  && ./obj_dir/tb_mem_ctrl | tee /dev/stderr | grep -q "Test passed" \
  && echo "simulation finished without errors" \
  || { echo "simulation reported errors or did not build"; exit 1; }

//--- tests/byte_ram.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module byte_ram (
  input  logic                      clk,
  input  logic [`MEM_ADDR_BITS-1:0] addr_i,
  input  logic                      we_i,
  input  logic [7:0]                din_i,
  output logic [7:0]                dout_o
);

  localparam int BYTES = 1 << `MEM_ADDR_BITS;

  // contents come straight from the testbench before reset ends
  logic [7:0] mem [BYTES];

  // one cycle read latency, a write returns the old byte
  always @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= din_i;
    end
    dout_o <= mem[addr_i];
  end

endmodule

//--- tests/tb_mem_ctrl.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module tb_mem_ctrl;

  import mem_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RAM_BYTES  = 1 << `MEM_ADDR_BITS;
  localparam int NUM_ROWS   = 19;

  typedef enum logic [2:0] {K_READ, K_WRITE, K_FETCH, K_RD_FETCH, K_WR_FETCH} kind_e;

  typedef struct packed {
    kind_e kind;
    addr_t addr;
    word_t wdata;
    size_e size;
    addr_t faddr;
    logic  hit;
  } row_t;

  logic                      clk;
  logic                      rst;
  logic                      data_req_i;
  mem_req_t                  data_cmd_i;
  logic                      data_done_o;
  word_t                     data_rdata_o;
  logic                      fetch_req_i;
  addr_t                     fetch_addr_i;
  logic                      fetch_done_o;
  word_t                     fetch_data_o;
  logic [`MEM_ADDR_BITS-1:0] ram_addr_o;
  logic                      ram_we_o;
  logic [7:0]                ram_dout_o;
  logic [7:0]                ram_din_i;

  logic [7:0] shadow [RAM_BYTES];
  int         errors = 0;
  int         seed = 63;

  // kind, data address, write data, size, fetch address, fetch expected to hit
  row_t rows [NUM_ROWS] = '{
    '{K_WRITE,    32'h0000_0400, 32'h0000_00A5, SZ_BYTE, 32'h0000_0000, 1'b0},
    '{K_READ,     32'h0000_0400, 32'h0000_0000, SZ_BYTE, 32'h0000_0000, 1'b0},
    '{K_WRITE,    32'h0000_0412, 32'h0000_BEEF, SZ_HALF, 32'h0000_0000, 1'b0},
    '{K_READ,     32'h0000_0412, 32'h0000_0000, SZ_HALF, 32'h0000_0000, 1'b0},
    '{K_WRITE,    32'h0000_0420, 32'h1234_5678, SZ_WORD, 32'h0000_0000, 1'b0},
    '{K_READ,     32'h0000_0420, 32'h0000_0000, SZ_WORD, 32'h0000_0000, 1'b0},
    '{K_READ,     32'h0000_0421, 32'h0000_0000, SZ_HALF, 32'h0000_0000, 1'b0},
    // first touch misses, the repeat hits
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0800, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0800, 1'b1},
    // store over a cached instruction word
    '{K_WRITE,    32'h0000_0800, 32'hCAFE_F00D, SZ_WORD, 32'h0000_0000, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0800, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0800, 1'b1},
    // index 0 with two tags, each evicts the other
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0900, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_1900, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_0900, 1'b0},
    '{K_FETCH,    32'h0000_0000, 32'h0000_0000, SZ_WORD, 32'h0000_1900, 1'b0},
    '{K_RD_FETCH, 32'h0000_0420, 32'h0000_0000, SZ_WORD, 32'h0000_2A04, 1'b0},
    '{K_WR_FETCH, 32'h0000_0430, 32'h55AA_1234, SZ_WORD, 32'h0000_2A04, 1'b1},
    '{K_WR_FETCH, 32'h0000_0440, 32'h0000_0077, SZ_BYTE, 32'h0000_3000, 1'b0}
  };

  mem_ctrl DUT (.*);

  byte_ram u_ram (
    .clk   (clk),
    .addr_i(ram_addr_o),
    .we_i  (ram_we_o),
    .din_i (ram_dout_o),
    .dout_o(ram_din_i)
  );

  // --------------------------------------------------
  // reference model and compares
  // --------------------------------------------------
  // little endian, bytes past the access size read as zero
  function automatic word_t expect_read(input addr_t a, input size_e sz);
    word_t                     w;
    logic [`MEM_ADDR_BITS-1:0] ba;
    w  = '0;
    ba = a[`MEM_ADDR_BITS-1:0];
    for (int i = 0; i <= int'(sz); i++) begin
      w[8*i +: 8] = shadow[ba];
      ba++;
    end
    return w;
  endfunction

  task automatic store_shadow(input addr_t a, input word_t wd, input size_e sz);
    logic [`MEM_ADDR_BITS-1:0] ba;
    ba = a[`MEM_ADDR_BITS-1:0];
    for (int i = 0; i <= int'(sz); i++) begin
      shadow[ba] = wd[8*i +: 8];
      ba++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // one table row, lat counts edges after the request edge
  // --------------------------------------------------
  task automatic apply_row(input row_t r, input int idx);
    logic  use_data;
    logic  use_fetch;
    logic  is_write;
    word_t exp_data;
    word_t exp_fetch;
    int    lat;
    int    d_lat;
    int    f_lat;
    int    exp_lat;
    use_data  = (r.kind != K_FETCH);
    use_fetch = (r.kind == K_FETCH) || (r.kind == K_RD_FETCH) || (r.kind == K_WR_FETCH);
    is_write  = (r.kind == K_WRITE) || (r.kind == K_WR_FETCH);
    exp_data  = expect_read(r.addr, r.size);
    exp_fetch = expect_read({r.faddr[31:2], 2'b00}, SZ_WORD);
    lat       = 0;
    d_lat     = use_data ? -1 : 0;
    f_lat     = use_fetch ? -1 : 0;
    @(posedge clk);
    if (use_data) begin
      data_req_i <= 1'b1;
      data_cmd_i <= '{addr: r.addr, wdata: r.wdata, write: is_write, size: r.size};
    end
    if (use_fetch) begin
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= r.faddr;
    end
    if (is_write) begin
      store_shadow(r.addr, r.wdata, r.size);
    end
    while (d_lat < 0 || f_lat < 0) begin
      @(negedge clk);
      if (d_lat < 0 && data_done_o) begin
        d_lat = lat;
        if (!is_write) begin
          check_word(data_rdata_o, exp_data, $sformatf("row %0d data read", idx));
        end
      end
      if (f_lat < 0 && fetch_done_o) begin
        f_lat = lat;
        check_word(fetch_data_o, exp_fetch, $sformatf("row %0d fetch", idx));
      end
      // a finished requester lets go at the edge that closes its done cycle
      @(posedge clk);
      if (d_lat >= 0) begin
        data_req_i <= 1'b0;
      end
      if (f_lat >= 0) begin
        fetch_req_i <= 1'b0;
      end
      lat++;
    end
    if (use_data) begin
      exp_lat = int'(r.size) + (is_write ? 2 : 3);
      check_flag(d_lat == exp_lat, 1'b1,
                 $sformatf("row %0d data done after %0d cycles, not %0d", idx, d_lat, exp_lat));
    end
    if (r.kind == K_FETCH) begin
      exp_lat = r.hit ? 1 : 7;
      check_flag(f_lat == exp_lat, 1'b1,
                 $sformatf("row %0d fetch done after %0d cycles, not %0d", idx, f_lat, exp_lat));
    end else if (use_fetch) begin
      // a hit finishes off the bus, a miss queues behind the data access
      check_flag(f_lat < d_lat, r.hit, $sformatf("row %0d fetch done ahead of data", idx));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // worst row stays well under 16 cycles
  initial begin
    #(NUM_ROWS * 16 * CLK_PERIOD);
    $display("run stalled, a done pulse never arrived within %0d table rows", NUM_ROWS);
    $display("Test failed");
    $finish;
  end

  initial begin
    word_t rnd;
    rst          = 1'b1;
    data_req_i   = 1'b0;
    data_cmd_i   = '0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    // same random bytes in the ram model and the shadow
    for (int i = 0; i < RAM_BYTES; i++) begin
      rnd          = $random(seed);
      u_ram.mem[i] = rnd[7:0];
      shadow[i]    = rnd[7:0];
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (8) begin
      @(negedge clk);
      check_flag(data_done_o, 1'b0, "data done while idle");
      check_flag(fetch_done_o, 1'b0, "fetch done while idle");
      check_flag(ram_we_o, 1'b0, "ram write while idle");
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i], i);
    end
    $display("tb_mem_ctrl: %0d rows run, %0d errors", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/mem_pkg.sv
design/icache.sv
design/mem_arbiter.sv
design/byte_bus_engine.sv
design/mem_ctrl.sv
tests/byte_ram.sv
tests/tb_mem_ctrl.sv
